// File: hdl/fetch_defs.svh
/*
  Fetch subsystem parameters
  Reset address, in-flight limit, sequence numbering and memory sizing
*/
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// First fetch address after reset
`define FETCH_RST_ADDR 32'h0000_0200
// Outstanding memory reads allowed
`define FETCH_MAX_IN_FLIGHT 16

// Sequence number space and commit slots per cycle
`define SEQ_NUM_BITS 5
`define RECLAIM_WIDTH 2

// Instruction memory sizing
`define IMEM_WORDS 256
`define IMEM_LATENCY 3
`define IMEM_QUEUE 4

`endif

// File: hdl/fetch_pkg.sv
/*
  Fetch package
  Bundles shared by fetch, sequence numbering and instruction memory
*/
`include "fetch_defs.svh"

package fetch_pkg;

  // Memory opcodes, fetch only ever reads
  typedef enum logic {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_op_e;

  // ------------------------------------------------
  // Memory request / response
  // ------------------------------------------------
  typedef struct packed {
    mem_op_e     op;
    logic [31:0] addr;
  } mem_req_t;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
  } mem_resp_t;

  // ------------------------------------------------
  // Decode hand-off and control notifications
  // ------------------------------------------------
  typedef struct packed {
    logic [31:0]               pc;
    logic [31:0]               inst;
    logic [`SEQ_NUM_BITS-1:0] seq_num;
  } fetch_pkt_t;

  typedef struct packed {
    logic                      val;
    logic [31:0]               target;
    logic [`SEQ_NUM_BITS-1:0] seq_num;
  } squash_t;

  // One commit slot, oldest in slot 0
  typedef struct packed {
    logic                      val;
    logic [`SEQ_NUM_BITS-1:0] seq_num;
  } commit_slot_t;

  typedef commit_slot_t [`RECLAIM_WIDTH-1:0] commit_t;

  // Memory fill port, word addressed
  typedef struct packed {
    logic        val;
    logic [7:0]  addr;
    logic [31:0] data;
  } imem_load_t;

endpackage

// File: hdl/seq_num_gen.sv
/*
  Sequence number generator
  Hands out numbers in order, reclaims them on commit, rewinds on squash
*/
`timescale 1ns/1ps

module seq_num_gen import fetch_pkg::*; #(
  parameter int bits          = 5,
  parameter int reclaim_width = 2
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            alloc_rdy,
  output logic            alloc_val,
  output logic [bits-1:0] alloc_seq_num,
  input  commit_t         commit,
  input  squash_t         squash
);

  localparam int cap      = 1 << bits;
  localparam int cnt_bits = bits + 1;
  localparam int rc_bits  = $clog2(reclaim_width + 1);

  // Oldest live number and next number to hand out
  logic [bits-1:0]     head;
  logic [bits-1:0]     tail;
  // Numbers currently in use, 0 to cap
  logic [cnt_bits-1:0] count;
  logic [rc_bits-1:0]  n_commit;
  logic [bits-1:0]     squash_gap;
  logic                alloc_xfer;

  // ------------------------------------------------
  // Commit slots this cycle
  // ------------------------------------------------
  always_comb begin
    n_commit = '0;
    for (int i = 0; i < reclaim_width; i++) begin
      if (commit[i].val) begin
        n_commit = n_commit + 1'b1;
      end
    end
  end

  // Distance from head to the squashing number
  assign squash_gap = bits'(squash.seq_num) - head;

  assign alloc_val     = count < cnt_bits'(cap);
  assign alloc_seq_num = tail;
  assign alloc_xfer    = alloc_val & alloc_rdy;

  // ------------------------------------------------
  // Head, tail and occupancy
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      // Commits always retire from the head
      head <= head + bits'(n_commit);
      if (squash.val) begin
        // Rewind to just past the squashing number
        tail  <= bits'(squash.seq_num) + 1'b1;
        count <= {1'b0, squash_gap} + 1'b1 - cnt_bits'(n_commit);
      end else begin
        if (alloc_xfer) begin
          tail <= tail + 1'b1;
        end
        count <= count + cnt_bits'(alloc_xfer) - cnt_bits'(n_commit);
      end
    end
  end

  // Occupancy stays within the number space
  a_count_bound: assert property (@(posedge clk) disable iff (rst)
    count <= cnt_bits'(cap));

  // Commit only for numbers handed out earlier
  a_no_commit_empty: assert property (@(posedge clk) disable iff (rst)
    (count == '0) |-> (n_commit == '0));

  // Commits hand numbers back in order from the head
  for (genvar i = 0; i < reclaim_width; i++) begin : g_commit_order
    a_commit_in_order: assert property (@(posedge clk) disable iff (rst)
      commit[i].val |-> (commit[i].seq_num == bits'(head + i)));
  end

endmodule

// File: hdl/fetch_unit.sv
/*
  Fetch unit
  Issues sequential reads, counts in-flight and squashed requests,
  drops stale responses and hands packets to decode
*/
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_unit import fetch_pkg::*; #(
  parameter int max_in_flight = 16
) (
  input  logic                      clk,
  input  logic                      rst,
  output logic                      mem_req_val,
  output mem_req_t                  mem_req,
  input  logic                      mem_req_rdy,
  input  logic                      mem_resp_val,
  input  mem_resp_t                 mem_resp,
  output logic                      mem_resp_rdy,
  output logic                      pkt_val,
  output fetch_pkt_t                pkt,
  input  logic                      pkt_rdy,
  input  logic                      alloc_val,
  input  logic [`SEQ_NUM_BITS-1:0] alloc_seq_num,
  output logic                      alloc_rdy,
  input  squash_t                   squash
);

  localparam int flight_bits = $clog2(max_in_flight) + 1;

  logic                   req_xfer;
  logic                   resp_xfer;
  // Response belongs to a squashed path
  logic                   drop;

  logic [flight_bits-1:0] in_flight;
  logic [flight_bits-1:0] in_flight_next;
  logic [flight_bits-1:0] to_squash;
  logic [flight_bits-1:0] to_squash_next;
  // One extra bit so the sum never wraps
  logic [flight_bits:0]   outstanding;

  logic [31:0]            curr_addr;

  assign req_xfer  = mem_req_val & mem_req_rdy;
  assign resp_xfer = mem_resp_val & mem_resp_rdy;
  assign drop      = squash.val | (to_squash != '0);

  // ------------------------------------------------
  // In-flight requests on the live path
  // ------------------------------------------------
  always_comb begin
    in_flight_next = in_flight;
    // Everything outstanding becomes stale
    if (squash.val) begin
      in_flight_next = '0;
    end
    if (req_xfer && (!resp_xfer || drop)) begin
      in_flight_next = in_flight_next + 1'b1;
    end else if (resp_xfer && !req_xfer && !drop) begin
      in_flight_next = in_flight_next - 1'b1;
    end
  end

  // ------------------------------------------------
  // Stale responses still to come back
  // ------------------------------------------------
  always_comb begin
    to_squash_next = to_squash;
    if (squash.val) begin
      to_squash_next = to_squash_next + in_flight;
    end
    // Each dropped response retires one stale entry
    if (resp_xfer && (to_squash_next != '0)) begin
      to_squash_next = to_squash_next - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      in_flight <= '0;
      to_squash <= '0;
    end else begin
      in_flight <= in_flight_next;
      to_squash <= to_squash_next;
    end
  end

  // ------------------------------------------------
  // Request address
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      curr_addr <= `FETCH_RST_ADDR;
    end else if (req_xfer) begin
      curr_addr <= mem_req.addr + 32'd4;
    end else if (squash.val) begin
      curr_addr <= squash.target;
    end
  end

  assign outstanding = {1'b0, in_flight} + {1'b0, to_squash};

  // Squash target goes out in the same cycle
  always_comb begin
    mem_req_val  = outstanding < (flight_bits + 1)'(max_in_flight);
    mem_req.op   = MEM_READ;
    mem_req.addr = squash.val ? squash.target : curr_addr;
  end

  // ------------------------------------------------
  // Response to decode
  // ------------------------------------------------
  always_comb begin
    // Stale responses drain regardless of decode
    mem_resp_rdy = (pkt_rdy & alloc_val) | drop;
    pkt_val      = mem_resp_val & alloc_val & ~drop;
    alloc_rdy    = pkt_val & pkt_rdy;
    pkt.pc       = mem_resp.addr;
    pkt.inst     = mem_resp.data;
    pkt.seq_num  = alloc_seq_num;
  end

  a_in_flight_bound: assert property (@(posedge clk) disable iff (rst)
    in_flight <= flight_bits'(max_in_flight));

  // Every accepted response matches a counted request
  a_resp_tracked: assert property (@(posedge clk) disable iff (rst)
    resp_xfer |-> (outstanding != '0));

endmodule

// File: hdl/inst_mem.sv
/*
  Instruction memory model
  Word array with fill port, fixed-latency read pipe and response queue
*/
`timescale 1ns/1ps

module inst_mem import fetch_pkg::*; #(
  parameter int words       = 256,
  parameter int latency     = 3,
  parameter int queue_depth = 4
) (
  input  logic       clk,
  input  logic       rst,
  input  imem_load_t load,
  input  logic       req_val,
  input  mem_req_t   req,
  output logic       req_rdy,
  output logic       resp_val,
  output mem_resp_t  resp,
  input  logic       resp_rdy
);

  localparam int idx_bits = $clog2(words);
  localparam int ptr_bits = (queue_depth > 1) ? $clog2(queue_depth) : 1;
  localparam int cnt_bits = $clog2(queue_depth + latency + 1);

  typedef struct packed {
    logic        val;
    logic [31:0] addr;
  } stage_t;

  logic [31:0]         mem [words];
  mem_resp_t           queue [queue_depth];

  stage_t              in_stage;
  // Stage that writes the queue
  stage_t              deliver;
  logic [ptr_bits-1:0] wr_ptr;
  logic [ptr_bits-1:0] rd_ptr;
  logic [cnt_bits-1:0] q_count;
  // Accepted but not yet queued
  logic [cnt_bits-1:0] pending;
  logic                deq;

  // Fill port
  always_ff @(posedge clk) begin
    if (load.val) begin
      mem[load.addr[idx_bits-1:0]] <= load.data;
    end
  end

  // ------------------------------------------------
  // Read pipeline
  // ------------------------------------------------
  assign in_stage.val  = req_val & req_rdy;
  assign in_stage.addr = req.addr;

  if (latency > 1) begin : g_pipe
    stage_t pipe [latency-1];

    always_ff @(posedge clk) begin
      pipe[0] <= in_stage;
      for (int i = 1; i < latency - 1; i++) begin
        pipe[i] <= pipe[i-1];
      end
      // Reset empties the pipe
      if (rst) begin
        for (int i = 0; i < latency - 1; i++) begin
          pipe[i].val <= 1'b0;
        end
      end
    end

    assign deliver = pipe[latency-2];
  end else begin : g_direct
    assign deliver = in_stage;
  end

  // ------------------------------------------------
  // Response queue
  // ------------------------------------------------
  assign deq      = resp_val & resp_rdy;
  assign resp_val = q_count != '0;
  assign resp     = queue[rd_ptr];
  // Reserve a slot for every request still in the pipe
  assign req_rdy  = (cnt_bits'(queue_depth) - q_count) > pending;

  always_ff @(posedge clk) begin
    if (deliver.val) begin
      queue[wr_ptr].addr <= deliver.addr;
      queue[wr_ptr].data <= mem[deliver.addr[idx_bits+1:2]];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      q_count <= '0;
      pending <= '0;
    end else begin
      if (deliver.val) begin
        wr_ptr <= (wr_ptr == ptr_bits'(queue_depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (deq) begin
        rd_ptr <= (rd_ptr == ptr_bits'(queue_depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      q_count <= q_count + cnt_bits'(deliver.val) - cnt_bits'(deq);
      pending <= pending + cnt_bits'(in_stage.val) - cnt_bits'(deliver.val);
    end
  end

  // Credit check keeps the queue from overflowing
  a_queue_no_overflow: assert property (@(posedge clk) disable iff (rst)
    deliver.val |-> (q_count < cnt_bits'(queue_depth)) || deq);

endmodule

// File: hdl/fetch_top.sv
/*
  Fetch subsystem top
  Fetch unit, sequence number generator and instruction memory
*/
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_top import fetch_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  imem_load_t load,
  output logic       pkt_val,
  output fetch_pkt_t pkt,
  input  logic       pkt_rdy,
  input  squash_t    squash,
  input  commit_t    commit
);

  // Fetch to memory
  logic                      mem_req_val;
  logic                      mem_req_rdy;
  mem_req_t                  mem_req;
  logic                      mem_resp_val;
  logic                      mem_resp_rdy;
  mem_resp_t                 mem_resp;

  // Sequence number grant
  logic                      alloc_val;
  logic                      alloc_rdy;
  logic [`SEQ_NUM_BITS-1:0] alloc_seq_num;

  // ------------------------------------------------
  // Fetch unit
  // ------------------------------------------------
  fetch_unit #(
    .max_in_flight (`FETCH_MAX_IN_FLIGHT)
  ) fetch_unit_i (
    .clk           (clk),
    .rst           (rst),
    .mem_req_val   (mem_req_val),
    .mem_req       (mem_req),
    .mem_req_rdy   (mem_req_rdy),
    .mem_resp_val  (mem_resp_val),
    .mem_resp      (mem_resp),
    .mem_resp_rdy  (mem_resp_rdy),
    .pkt_val       (pkt_val),
    .pkt           (pkt),
    .pkt_rdy       (pkt_rdy),
    .alloc_val     (alloc_val),
    .alloc_seq_num (alloc_seq_num),
    .alloc_rdy     (alloc_rdy),
    .squash        (squash)
  );

  // Numbers reclaimed by commit, rewound by squash
  seq_num_gen #(
    .bits          (`SEQ_NUM_BITS),
    .reclaim_width (`RECLAIM_WIDTH)
  ) seq_num_gen_i (
    .clk           (clk),
    .rst           (rst),
    .alloc_rdy     (alloc_rdy),
    .alloc_val     (alloc_val),
    .alloc_seq_num (alloc_seq_num),
    .commit        (commit),
    .squash        (squash)
  );

  // ------------------------------------------------
  // Instruction memory
  // ------------------------------------------------
  inst_mem #(
    .words       (`IMEM_WORDS),
    .latency     (`IMEM_LATENCY),
    .queue_depth (`IMEM_QUEUE)
  ) inst_mem_i (
    .clk      (clk),
    .rst      (rst),
    .load     (load),
    .req_val  (mem_req_val),
    .req      (mem_req),
    .req_rdy  (mem_req_rdy),
    .resp_val (mem_resp_val),
    .resp     (mem_resp),
    .resp_rdy (mem_resp_rdy)
  );

endmodule

// File: tb/fetch_checks.svh
/*
  Fetch testbench checks
  Typed compare tasks and bounded waits on the packet stream
*/
`ifndef FETCH_CHECKS_SVH
`define FETCH_CHECKS_SVH

// --------------------------------------------------
// Compare tasks
// --------------------------------------------------
task automatic check_pkt(string name, fetch_pkt_t exp, fetch_pkt_t act);
  if (exp !== act) begin
    fail_stop($sformatf("Mismatch %s: expected pc=%h inst=%h seq=%0d, actual pc=%h inst=%h seq=%0d",
                        name, exp.pc, exp.inst, exp.seq_num, act.pc, act.inst, act.seq_num));
  end
endtask

task automatic check_bit(string name, logic exp, logic act);
  if (exp !== act) begin
    fail_stop($sformatf("Mismatch %s: expected %b, actual %b", name, exp, act));
  end
endtask

// --------------------------------------------------
// Bounded waits
// --------------------------------------------------
// Until the monitor has counted target hand-offs
task automatic wait_delivered(int target, int limit);
  int cycles;
  cycles = 0;
  while (delivered < target) begin
    @(posedge clk);
    cycles++;
    if (cycles > limit) begin
      fail_stop($sformatf("Timeout: %0d of %0d packets arrived in %0d cycles",
                          delivered, target, limit));
    end
  end
endtask

// Until target numbers are delivered but not committed
task automatic wait_in_use(int target, int limit);
  int cycles;
  cycles = 0;
  while ((delivered - committed) < target) begin
    @(posedge clk);
    cycles++;
    if (cycles > limit) begin
      fail_stop($sformatf("Timeout: only %0d sequence numbers in use after %0d cycles",
                          delivered - committed, limit));
    end
  end
endtask

// Next hand-off, returns its expected sequence number
task automatic wait_handoff(output logic [`SEQ_NUM_BITS-1:0] seq, input int limit);
  int   cycles;
  logic seen;
  cycles = 0;
  seen   = 1'b0;
  while (!seen) begin
    @(posedge clk);
    if (pkt_val && pkt_rdy) begin
      seen = 1'b1;
      seq  = exp_seq;
    end else begin
      cycles++;
      if (cycles > limit) begin
        fail_stop($sformatf("Timeout: no packet handed to decode in %0d cycles", limit));
      end
    end
  end
endtask

`endif

// File: tb/fetch_tb.sv
/*
  Fetch subsystem testbench
  Random decode back-pressure, squash redirects and sequence number stalls
*/
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_tb import fetch_pkg::*; ();

  logic       clk     = 1'b0;
  logic       rst;
  imem_load_t load;
  logic       pkt_val;
  fetch_pkt_t pkt;
  logic       pkt_rdy = 1'b0;
  squash_t    squash;
  commit_t    commit  = '0;

  // Copy of the memory image
  logic [31:0] mirror [`IMEM_WORDS];

  // Monitor state, all updated on the clock edge
  logic [31:0]              exp_pc    = `FETCH_RST_ADDR;
  logic [`SEQ_NUM_BITS-1:0] exp_seq   = '0;
  int                       delivered = 0;
  int                       committed = 0;
  logic                     commit_en = 1'b0;
  logic                     stall_chk = 1'b0;
  string                    test_name = "reset";

  fetch_top fetch_top_i (
    .clk     (clk),
    .rst     (rst),
    .load    (load),
    .pkt_val (pkt_val),
    .pkt     (pkt),
    .pkt_rdy (pkt_rdy),
    .squash  (squash),
    .commit  (commit)
  );

  // 4 ns period
  always #2 clk = ~clk;

  task automatic fail_stop(string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1, "Run stopped at first error");
  endtask

  `include "fetch_checks.svh"

  // Word at pc[9:2] of the mirror, tagged with seq
  function automatic fetch_pkt_t expected_pkt(logic [31:0] pc, logic [`SEQ_NUM_BITS-1:0] seq);
    fetch_pkt_t p;
    p.pc      = pc;
    p.inst    = mirror[pc[9:2]];
    p.seq_num = seq;
    return p;
  endfunction

  // --------------------------------------------------
  // Monitor and compare
  // --------------------------------------------------
  always @(posedge clk) begin
    if (rst) begin
      exp_pc    <= `FETCH_RST_ADDR;
      exp_seq   <= '0;
      delivered <= 0;
    end else if (squash.val) begin
      // Redirect, numbering resumes past the squashing one
      check_bit({test_name, " packet in squash cycle"}, 1'b0, pkt_val);
      exp_pc  <= squash.target;
      exp_seq <= squash.seq_num + 1'b1;
    end else begin
      if (pkt_val && pkt_rdy) begin
        check_pkt(test_name, expected_pkt(exp_pc, exp_seq), pkt);
        exp_pc    <= exp_pc + 32'd4;
        exp_seq   <= exp_seq + 1'b1;
        delivered <= delivered + 1;
      end
      if (stall_chk) begin
        check_bit({test_name, " pkt_val while out of numbers"}, 1'b0, pkt_val);
      end
    end
  end

  // --------------------------------------------------
  // Decode back-pressure and in-order commits
  // --------------------------------------------------
  always @(posedge clk) begin
    commit_t c;
    int      n;
    if (rst) begin
      pkt_rdy   <= 1'b0;
      commit    <= '0;
      committed <= 0;
    end else begin
      pkt_rdy <= ($urandom_range(3) != 0);
      n = commit_en ? $urandom_range(`RECLAIM_WIDTH) : 0;
      // Only numbers already handed to decode
      if (n > delivered - committed) begin
        n = delivered - committed;
      end
      for (int k = 0; k < `RECLAIM_WIDTH; k++) begin
        c[k].val     = (k < n);
        c[k].seq_num = `SEQ_NUM_BITS'(committed + k);
      end
      commit    <= c;
      committed <= committed + n;
    end
  end

  // Squash right after a hand-off, naming that packet
  task automatic redirect(logic [31:0] dest);
    logic [`SEQ_NUM_BITS-1:0] last_seq;
    wait_handoff(last_seq, 500);
    squash <= '{val: 1'b1, target: dest, seq_num: last_seq};
    @(posedge clk);
    squash <= '0;
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    logic [31:0] dests [3];
    int          base;
    rst    = 1'b1;
    load   = '0;
    squash = '0;
    dests  = '{32'h0000_0100, 32'h0000_03f0, 32'h0000_0040};
    void'($urandom(55973));
    for (int i = 0; i < `IMEM_WORDS; i++) begin
      mirror[i] = $urandom;
    end

    // Fill under reset, one word per cycle
    for (int i = 0; i < `IMEM_WORDS; i++) begin
      @(posedge clk);
      load <= '{val: 1'b1, addr: i[7:0], data: mirror[i]};
    end
    @(posedge clk);
    load <= '0;
    repeat (10) @(posedge clk);
    rst       <= 1'b0;
    commit_en <= 1'b1;
    test_name <= "sequential";
    @(posedge clk);
    check_bit("pkt_val after reset", 1'b0, pkt_val);
    wait_delivered(60, 3000);

    // Redirects, including one across the 1 KB wrap
    test_name <= "squash";
    for (int i = 0; i < 3; i++) begin
      redirect(dests[i]);
      base = delivered;
      wait_delivered(base + 20, 2000);
    end

    // Without commits the number space runs dry
    test_name <= "no commit";
    commit_en <= 1'b0;
    wait_in_use(1 << `SEQ_NUM_BITS, 3000);
    base = delivered;
    stall_chk <= 1'b1;
    repeat (200) @(posedge clk);
    stall_chk <= 1'b0;

    test_name <= "resume";
    commit_en <= 1'b1;
    wait_delivered(base + 40, 3000);

    $display("Finished with no errors");
    $finish;
  end

endmodule

// File: fetch_sub.f
+incdir+hdl
+incdir+tb
hdl/fetch_pkg.sv
hdl/seq_num_gen.sv
hdl/fetch_unit.sv
hdl/inst_mem.sv
hdl/fetch_top.sv
tb/fetch_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --assert -j 0
LINT     = --lint-only --timing --assert
TOP      = fetch_tb
FILELIST = fetch_sub.f
PASS_MSG = Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(SIM) $(LINT) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
